/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

	// ====================
	// Widths
	// ====================
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int NUM_PORTS = 3;
	localparam int PORT_W = $clog2(NUM_PORTS);

	// Master port numbering
	localparam int PORT_INSTR = 0;
	localparam int PORT_DATA = 1;
	localparam int PORT_DMA = 2;

	// ====================
	// Bus records
	// ====================
	typedef struct packed {
		logic              request;
		logic              rw;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] wdata;
	} port_req_t;

	typedef struct packed {
		logic              ready;
		logic              busy;
		logic [DATA_W-1:0] rdata;
	} port_rsp_t;

	typedef struct packed {
		logic              request;
		logic              rw;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic              ready;
		logic [DATA_W-1:0] rdata;
	} bus_rsp_t;

	typedef enum logic {
		ARB_FIXED       = 1'b0,
		ARB_ROUND_ROBIN = 1'b1
	} arb_mode_t;

endpackage

`default_nettype wire

/* src/map_pkg.sv */
`default_nettype none

package map_pkg;

	// ====================
	// Regions
	// ====================
	// Top nibble of the address picks the target
	localparam int REGION_MSB = 31;
	localparam int REGION_LSB = 28;

	typedef logic [REGION_MSB-REGION_LSB:0] region_t;

	localparam region_t REGION_ROM = 4'h0;
	localparam region_t REGION_RAM = 4'h1;
	localparam region_t REGION_REGS = 4'h2;

	// ====================
	// Memories
	// ====================
	localparam int ROM_WORDS = 16;
	localparam int ROM_AW = $clog2(ROM_WORDS);
	localparam string ROM_HEX_FILE = "src/boot_rom.hex";

	localparam int RAM_WORDS = 1024;
	localparam int RAM_AW = $clog2(RAM_WORDS);

	// ====================
	// Control registers
	// ====================
	// Word offsets inside region 2
	localparam int REG_AW = 2;

	localparam logic [REG_AW-1:0] REG_CTRL = 2'd0;
	localparam logic [REG_AW-1:0] REG_FAULT_COUNT = 2'd1;
	localparam logic [REG_AW-1:0] REG_FAULT_ADDR = 2'd2;

	// CTRL bit holding the arbitration mode
	localparam int CTRL_MODE_BIT = 0;

endpackage

`default_nettype wire

/* src/bus_arbiter.sv */
`default_nettype none

module bus_arbiter
	import bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_rst_n,

	input  wire port_req_t i_port_req [NUM_PORTS],
	output port_rsp_t      o_port_rsp [NUM_PORTS],

	input  wire arb_mode_t i_arb_mode,

	output bus_req_t       o_bus_req,
	input  wire bus_rsp_t  i_bus_rsp
);

	logic [NUM_PORTS-1:0] req_vec;
	logic [NUM_PORTS-1:0] grant_q;
	logic [NUM_PORTS-1:0] grant_next;
	logic [PORT_W-1:0]    grant_idx;
	logic [PORT_W-1:0]    last_q;
	logic                 start;

	logic                 rw_q;
	logic [ADDR_W-1:0]    address_q;
	logic [DATA_W-1:0]    wdata_q;

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			req_vec[i] = i_port_req[i].request;
		end
	end

	// ====================
	// Grant selection
	// ====================
	always_comb begin
		int idx;
		idx = 0;
		grant_next = '0;
		grant_idx = last_q;
		if (i_arb_mode == ARB_FIXED) begin
			// Data first, then instruction, then DMA
			if (req_vec[PORT_DATA]) begin
				grant_idx = PORT_W'(PORT_DATA);
			end else if (req_vec[PORT_INSTR]) begin
				grant_idx = PORT_W'(PORT_INSTR);
			end else if (req_vec[PORT_DMA]) begin
				grant_idx = PORT_W'(PORT_DMA);
			end
		end else begin
			// Walk backwards so the port right after last_q wins
			for (int k = NUM_PORTS; k >= 1; k--) begin
				idx = (int'(last_q) + k) % NUM_PORTS;
				if (req_vec[idx]) begin
					grant_idx = PORT_W'(idx);
				end
			end
		end
		if (req_vec != '0) begin
			grant_next[grant_idx] = 1'b1;
		end
	end

	// New grant only from the idle state
	assign start = (grant_q == '0) && (req_vec != '0);

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			grant_q <= '0;
			last_q <= PORT_W'(PORT_DMA);
		end else if (start) begin
			grant_q <= grant_next;
			last_q <= grant_idx;
		end else if (i_bus_rsp.ready) begin
			grant_q <= '0;
		end
	end

	// Fields of the winning port
	always_ff @(posedge i_clock) begin
		if (start) begin
			rw_q <= i_port_req[grant_idx].rw;
			address_q <= i_port_req[grant_idx].address;
			wdata_q <= i_port_req[grant_idx].wdata;
		end
	end

	// ====================
	// Outputs
	// ====================
	always_comb begin
		o_bus_req.request = |grant_q;
		o_bus_req.rw = rw_q;
		o_bus_req.address = address_q;
		o_bus_req.wdata = wdata_q;
	end

	always_comb begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			o_port_rsp[i].ready = grant_q[i] & i_bus_rsp.ready;
			o_port_rsp[i].busy = req_vec[i] & (grant_q != '0) & ~grant_q[i];
			o_port_rsp[i].rdata = grant_q[i] ? i_bus_rsp.rdata : '0;
		end
	end

	// ====================
	// Checks
	// ====================
	a_grant_onehot: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$onehot0(grant_q));

	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_ready_chk
		a_ready_has_req: assert property (@(posedge i_clock) disable iff (!i_rst_n)
			o_port_rsp[g].ready |-> i_port_req[g].request);

		// A waiting master keeps its request and fields until ready
		a_req_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
			(i_port_req[g].request && !o_port_rsp[g].ready) |=> $stable(i_port_req[g]));
	end

endmodule

`default_nettype wire

/* src/addr_decoder.sv */
`default_nettype none

module addr_decoder
	import bus_pkg::*;
	import map_pkg::*;
(
	input  wire bus_req_t  i_bus_req,
	output bus_rsp_t       o_bus_rsp,

	output logic           o_rom_request,
	output logic           o_ram_request,
	output logic           o_reg_request,

	input  wire bus_rsp_t  i_rom_rsp,
	input  wire bus_rsp_t  i_ram_rsp,
	input  wire bus_rsp_t  i_reg_rsp,

	output logic              o_fault,
	output logic [ADDR_W-1:0] o_fault_address
);

	region_t region;
	logic    rom_select;
	logic    ram_select;
	logic    reg_select;
	logic    mapped;

	assign region = i_bus_req.address[REGION_MSB:REGION_LSB];

	assign rom_select = (region == REGION_ROM);
	assign ram_select = (region == REGION_RAM);
	assign reg_select = (region == REGION_REGS);
	assign mapped = rom_select | ram_select | reg_select;

	// Request goes to one target only
	assign o_rom_request = i_bus_req.request & rom_select;
	assign o_ram_request = i_bus_req.request & ram_select;
	assign o_reg_request = i_bus_req.request & reg_select;

	// Unmapped cycle ends right away so the bus cannot hang
	assign o_fault = i_bus_req.request & ~mapped;
	assign o_fault_address = i_bus_req.address;

	// ====================
	// Response mux
	// ====================
	always_comb begin
		if (rom_select) begin
			o_bus_rsp = i_rom_rsp;
		end else if (ram_select) begin
			o_bus_rsp = i_ram_rsp;
		end else if (reg_select) begin
			o_bus_rsp = i_reg_rsp;
		end else begin
			o_bus_rsp.ready = o_fault;
			o_bus_rsp.rdata = '0;
		end
	end

	// Targets answer only while the bus still requests
	always_comb begin
		a_ready_needs_request: assert final (!o_bus_rsp.ready || i_bus_req.request);
	end

endmodule

`default_nettype wire

/* src/boot_rom.sv */
`default_nettype none

module boot_rom
	import bus_pkg::*;
	import map_pkg::*;
(
	input  wire logic              i_clock,
	input  wire logic              i_request,
	input  wire logic [ADDR_W-1:0] i_address,
	output bus_rsp_t               o_rsp
);

	logic [DATA_W-1:0] rom_mem [ROM_WORDS];
	logic [ROM_AW-1:0] word_idx;
	logic              ready_q;
	logic [DATA_W-1:0] rdata_q;

	initial begin
		$readmemh(ROM_HEX_FILE, rom_mem);
	end

	// Word index wraps at the ROM depth
	assign word_idx = i_address[ROM_AW+1:2];

	// Request stays up through the ready cycle and is answered once
	always_ff @(posedge i_clock) begin
		ready_q <= i_request & ~ready_q;
		if (i_request && !ready_q) begin
			rdata_q <= rom_mem[word_idx];
		end
	end

	// Writes just read back the word
	always_comb begin
		o_rsp.ready = ready_q;
		o_rsp.rdata = rdata_q;
	end

endmodule

`default_nettype wire

/* src/sram.sv */
`default_nettype none

module sram
	import bus_pkg::*;
	import map_pkg::*;
(
	input  wire logic              i_clock,
	input  wire logic              i_rst_n,
	input  wire logic              i_request,
	input  wire logic              i_rw,
	input  wire logic [ADDR_W-1:0] i_address,
	input  wire logic [DATA_W-1:0] i_wdata,
	output bus_rsp_t               o_rsp
);

	logic [DATA_W-1:0] ram_mem [RAM_WORDS];
	logic [RAM_AW-1:0] word_idx;
	logic              accept;
	logic              ready_q;
	logic [DATA_W-1:0] rdata_q;

	assign word_idx = i_address[RAM_AW+1:2];

	// Request stays high in the ready cycle and is skipped there
	assign accept = i_request & ~ready_q;

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= accept;
		end
	end

	always_ff @(posedge i_clock) begin
		if (accept) begin
			if (i_rw) begin
				ram_mem[word_idx] <= i_wdata;
				rdata_q <= '0;
			end else begin
				rdata_q <= ram_mem[word_idx];
			end
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;

	// The bus holds its request until it has seen ready
	a_ready_in_request: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		ready_q |-> i_request);

endmodule

`default_nettype wire

/* src/bus_ctrl_regs.sv */
`default_nettype none

module bus_ctrl_regs
	import bus_pkg::*;
	import map_pkg::*;
(
	input  wire logic              i_clock,
	input  wire logic              i_rst_n,

	input  wire logic              i_request,
	input  wire logic              i_rw,
	input  wire logic [ADDR_W-1:0] i_address,
	input  wire logic [DATA_W-1:0] i_wdata,
	output bus_rsp_t               o_rsp,

	input  wire logic              i_fault,
	input  wire logic [ADDR_W-1:0] i_fault_address,

	output arb_mode_t              o_arb_mode
);

	logic [REG_AW-1:0] reg_idx;
	logic              accept;
	logic              ready_q;
	logic [DATA_W-1:0] rdata_q;
	arb_mode_t         mode_q;
	logic [DATA_W-1:0] fault_count_q;
	logic [ADDR_W-1:0] fault_addr_q;

	assign reg_idx = i_address[REG_AW+1:2];
	assign accept = i_request & ~ready_q;

	// ====================
	// Register state
	// ====================
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ready_q <= 1'b0;
			mode_q <= ARB_FIXED;
			fault_count_q <= '0;
			fault_addr_q <= '0;
		end else begin
			ready_q <= accept;
			// Only CTRL takes writes
			if (accept && i_rw && reg_idx == REG_CTRL) begin
				mode_q <= arb_mode_t'(i_wdata[CTRL_MODE_BIT]);
			end
			if (i_fault) begin
				fault_addr_q <= i_fault_address;
				if (fault_count_q != '1) begin
					fault_count_q <= fault_count_q + 1'b1;
				end
			end
		end
	end

	// Writes answer with zero read data
	always_ff @(posedge i_clock) begin
		if (accept) begin
			rdata_q <= '0;
			if (!i_rw) begin
				case (reg_idx)
					REG_CTRL:        rdata_q[CTRL_MODE_BIT] <= mode_q;
					REG_FAULT_COUNT: rdata_q <= fault_count_q;
					REG_FAULT_ADDR:  rdata_q <= fault_addr_q;
					default:         rdata_q <= '0;
				endcase
			end
		end
	end

	assign o_rsp.ready = ready_q;
	assign o_rsp.rdata = rdata_q;
	assign o_arb_mode = mode_q;

endmodule

`default_nettype wire

/* src/mem_subsystem.sv */
`default_nettype none

module mem_subsystem
	import bus_pkg::*;
(
	input  wire logic      i_clock,
	input  wire logic      i_rst_n,

	input  wire port_req_t i_port_req [NUM_PORTS],
	output port_rsp_t      o_port_rsp [NUM_PORTS]
);

	bus_req_t          bus_req;
	bus_rsp_t          bus_rsp;
	bus_rsp_t          rom_rsp;
	bus_rsp_t          ram_rsp;
	bus_rsp_t          reg_rsp;
	logic              rom_request;
	logic              ram_request;
	logic              reg_request;
	logic              fault;
	logic [ADDR_W-1:0] fault_address;
	arb_mode_t         arb_mode;

	// ====================
	// Masters and arbitration
	// ====================
	bus_arbiter arbiter_i (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_port_req (i_port_req),
		.o_port_rsp (o_port_rsp),
		.i_arb_mode (arb_mode),
		.o_bus_req  (bus_req),
		.i_bus_rsp  (bus_rsp)
	);

	// Steers the arbiter and serves region 2
	bus_ctrl_regs ctrl_i (
		.i_clock         (i_clock),
		.i_rst_n         (i_rst_n),
		.i_request       (reg_request),
		.i_rw            (bus_req.rw),
		.i_address       (bus_req.address),
		.i_wdata         (bus_req.wdata),
		.o_rsp           (reg_rsp),
		.i_fault         (fault),
		.i_fault_address (fault_address),
		.o_arb_mode      (arb_mode)
	);

	// ====================
	// Decode and targets
	// ====================
	addr_decoder decoder_i (
		.i_bus_req       (bus_req),
		.o_bus_rsp       (bus_rsp),
		.o_rom_request   (rom_request),
		.o_ram_request   (ram_request),
		.o_reg_request   (reg_request),
		.i_rom_rsp       (rom_rsp),
		.i_ram_rsp       (ram_rsp),
		.i_reg_rsp       (reg_rsp),
		.o_fault         (fault),
		.o_fault_address (fault_address)
	);

	boot_rom rom_i (
		.i_clock   (i_clock),
		.i_request (rom_request),
		.i_address (bus_req.address),
		.o_rsp     (rom_rsp)
	);

	sram ram_i (
		.i_clock   (i_clock),
		.i_rst_n   (i_rst_n),
		.i_request (ram_request),
		.i_rw      (bus_req.rw),
		.i_address (bus_req.address),
		.i_wdata   (bus_req.wdata),
		.o_rsp     (ram_rsp)
	);

endmodule

`default_nettype wire

/* dv/tb_mem_subsystem.sv */
`default_nettype none

module tb_mem_subsystem
	import bus_pkg::*;
	import map_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_ACCESSES = 103;
	localparam int READY_LIMIT = 40;
	localparam int TIMEOUT = (NUM_ACCESSES * 20 + 500) * CLK_PERIOD;

	logic              clock;
	logic              rst_n;
	port_req_t         port_req [NUM_PORTS];
	port_rsp_t         port_rsp [NUM_PORTS];
	logic [DATA_W-1:0] rom_model [ROM_WORDS];
	int                ready_order [$];
	int                error_count = 0;
	int                check_count = 0;
	logic [31:0]       lcg_state = 32'd67;

	mem_subsystem dut_i (
		.i_clock    (clock),
		.i_rst_n    (rst_n),
		.i_port_req (port_req),
		.o_port_rsp (port_rsp)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [ADDR_W-1:0] region_addr(input region_t region, input int word);
		return {region, 28'(word * 4)};
	endfunction

	task automatic check_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One access on one port with outputs sampled at the falling edge
	task automatic bus_access(input int port, input logic rw, input logic [ADDR_W-1:0] address,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
			output logic saw_busy, output int latency);
		int   cycles;
		logic got;
		cycles = 0;
		got = 1'b0;
		saw_busy = 1'b0;
		rdata = '0;
		latency = -1;
		@(posedge clock);
		#2;
		port_req[port].request = 1'b1;
		port_req[port].rw = rw;
		port_req[port].address = address;
		port_req[port].wdata = wdata;
		while (!got && cycles < READY_LIMIT) begin
			@(negedge clock);
			if (port_rsp[port].busy) begin
				saw_busy = 1'b1;
			end
			if (port_rsp[port].ready) begin
				got = 1'b1;
				rdata = port_rsp[port].rdata;
				latency = cycles;
				ready_order.push_back(port);
			end
			cycles++;
		end
		if (!got) begin
			error_count++;
			$display("Port %0d got no ready within %0d cycles for address %h",
				port, READY_LIMIT, address);
		end
		@(posedge clock);
		#2;
		port_req[port].request = 1'b0;
	endtask

	task automatic read_word(input int port, input logic [ADDR_W-1:0] address,
			output logic [DATA_W-1:0] rdata);
		logic busy_seen;
		int   latency;
		bus_access(port, 1'b0, address, '0, rdata, busy_seen, latency);
	endtask

	task automatic write_word(input int port, input logic [ADDR_W-1:0] address,
			input logic [DATA_W-1:0] wdata);
		logic [DATA_W-1:0] rdata;
		logic              busy_seen;
		int                latency;
		bus_access(port, 1'b1, address, wdata, rdata, busy_seen, latency);
	endtask

	// All three ports read the ROM in the same cycle
	task automatic all_ports_read(input string name, input int first, input int second,
			input int third);
		logic [DATA_W-1:0] rd [NUM_PORTS];
		logic              bz [NUM_PORTS];
		int                lat [NUM_PORTS];
		int                expected_order [3];
		expected_order = '{first, second, third};
		ready_order.delete();
		fork
			bus_access(PORT_INSTR, 1'b0, region_addr(REGION_ROM, 1), '0,
				rd[PORT_INSTR], bz[PORT_INSTR], lat[PORT_INSTR]);
			bus_access(PORT_DATA, 1'b0, region_addr(REGION_ROM, 6), '0,
				rd[PORT_DATA], bz[PORT_DATA], lat[PORT_DATA]);
			bus_access(PORT_DMA, 1'b0, region_addr(REGION_ROM, 11), '0,
				rd[PORT_DMA], bz[PORT_DMA], lat[PORT_DMA]);
		join
		check_equal({name, " ready count"}, 3, ready_order.size());
		for (int k = 0; k < 3 && k < ready_order.size(); k++) begin
			check_equal({name, " ready order"}, expected_order[k], ready_order[k]);
		end
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_equal({name, " rdata"}, rom_model[p * 5 + 1], rd[p]);
		end
		// Only the winner never waits
		check_equal({name, " first busy"}, 0, bz[first]);
		check_equal({name, " second busy"}, 1, bz[second]);
		check_equal({name, " third busy"}, 1, bz[third]);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic reset_state();
		logic [DATA_W-1:0] rd;
		logic              bz;
		int                lat;
		@(negedge clock);
		for (int p = 0; p < NUM_PORTS; p++) begin
			check_equal("reset ready", 0, port_rsp[p].ready);
			check_equal("reset busy", 0, port_rsp[p].busy);
		end
		bus_access(PORT_DATA, 1'b0, region_addr(REGION_REGS, REG_CTRL), '0, rd, bz, lat);
		check_equal("reset ctrl", 0, rd);
		check_equal("reset latency", 2, lat);
	endtask

	task automatic rom_reads();
		logic [DATA_W-1:0] rd;
		for (int p = 0; p < NUM_PORTS; p++) begin
			for (int w = 0; w < ROM_WORDS; w++) begin
				read_word(p, region_addr(REGION_ROM, w), rd);
				check_equal("rom read", rom_model[w], rd);
			end
		end
		write_word(PORT_DATA, region_addr(REGION_ROM, 2), 32'hdead_beef);
		read_word(PORT_INSTR, region_addr(REGION_ROM, 2), rd);
		check_equal("rom write ignored", rom_model[2], rd);
	endtask

	task automatic ram_write_read();
		logic [DATA_W-1:0] expected [8];
		logic [DATA_W-1:0] rd;
		for (int i = 0; i < 8; i++) begin
			expected[i] = lcg_next();
			write_word((i % 2 == 0) ? PORT_DATA : PORT_DMA,
				region_addr(REGION_RAM, i * 37), expected[i]);
		end
		// Every port sees every write
		for (int i = 0; i < 8; i++) begin
			for (int p = 0; p < NUM_PORTS; p++) begin
				read_word(p, region_addr(REGION_RAM, i * 37), rd);
				check_equal("ram readback", expected[i], rd);
			end
		end
	endtask

	task automatic fault_handling();
		logic [DATA_W-1:0] rd;
		logic              bz;
		int                lat;
		bus_access(PORT_DATA, 1'b0, 32'h5000_0010, '0, rd, bz, lat);
		check_equal("fault rdata", 0, rd);
		check_equal("fault latency", 1, lat);
		read_word(PORT_INSTR, 32'h5000_0abc, rd);
		check_equal("fault rdata", 0, rd);
		write_word(PORT_DMA, 32'hf000_0004, 32'h1234_5678);
		read_word(PORT_DATA, region_addr(REGION_REGS, REG_FAULT_COUNT), rd);
		check_equal("fault count", 3, rd);
		read_word(PORT_DATA, region_addr(REGION_REGS, REG_FAULT_ADDR), rd);
		check_equal("fault address", 32'hf000_0004, rd);
		// Read-only registers
		write_word(PORT_DATA, region_addr(REGION_REGS, REG_FAULT_COUNT), 32'hffff_ffff);
		write_word(PORT_DATA, region_addr(REGION_REGS, REG_FAULT_ADDR), 32'hffff_ffff);
		read_word(PORT_DMA, region_addr(REGION_REGS, REG_FAULT_COUNT), rd);
		check_equal("fault count read-only", 3, rd);
		read_word(PORT_DMA, region_addr(REGION_REGS, REG_FAULT_ADDR), rd);
		check_equal("fault address read-only", 32'hf000_0004, rd);
	endtask

	task automatic fixed_priority();
		all_ports_read("fixed priority", PORT_DATA, PORT_INSTR, PORT_DMA);
	endtask

	task automatic round_robin();
		logic [DATA_W-1:0] rd;
		// DMA served last, so instruction leads the first round
		write_word(PORT_DMA, region_addr(REGION_REGS, REG_CTRL), 32'd1);
		read_word(PORT_DMA, region_addr(REGION_REGS, REG_CTRL), rd);
		check_equal("round robin ctrl", 1, rd);
		repeat (2) begin
			all_ports_read("round robin", PORT_INSTR, PORT_DATA, PORT_DMA);
		end
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin : main
		rst_n = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++) begin
			port_req[p] = '0;
		end
		$readmemh("src/boot_rom.hex", rom_model);
		repeat (5) @(posedge clock);
		#2;
		rst_n = 1'b1;

		reset_state();
		rom_reads();
		ram_write_read();
		fault_handling();
		fixed_priority();
		round_robin();

		$display("Summary: %0d checks run, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT);
		$display("Watchdog: run exceeded %0d time units and was stopped", TIMEOUT);
		$display("Summary: %0d checks run, %0d errors", check_count, error_count);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* src/boot_rom.hex */
// One 32-bit boot ROM word per line, word address 0 first
00000297
02028293
30529073
00001117
ff410113
100002b7
00028313
00032383
0072a023
00430313
fe0398e3
200002b7
0002a503
00150513
00a2a023
0000006f

/* mem_subsystem.f */
src/bus_pkg.sv
src/map_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/boot_rom.sv
src/sram.sv
src/bus_ctrl_regs.sv
src/mem_subsystem.sv
dv/tb_mem_subsystem.sv
